//--- include/vc_router_cfg.svh
// ==================================================
// vc_router configuration
// sizes shared by the router RTL and its testbench
// ==================================================
`ifndef VC_ROUTER_CFG_SVH
`define VC_ROUTER_CFG_SVH

// physical ports, each with one input and one output
`define VC_ROUTER_NUM_PORTS 3

// virtual channels per port
`define VC_ROUTER_NUM_VC 2

// flits per VC buffer
// also the initial credits per downstream VC
`define VC_ROUTER_VC_DEPTH 2

// flit payload bits
`define VC_ROUTER_PAYLOAD_W 16

`endif

//--- src/vc_router_pkg.sv
// ==================================================
// vc_router types
// index widths, masks, the flit and lock states
// ==================================================
`default_nettype none
`include "vc_router_cfg.svh"

package vc_router_pkg;

  // port and VC numbers
  typedef logic [$clog2(`VC_ROUTER_NUM_PORTS)-1:0] port_idx_t;
  typedef logic [$clog2(`VC_ROUTER_NUM_VC)-1:0]    vc_idx_t;

  // 0 up to a full buffer
  typedef logic [$clog2(`VC_ROUTER_VC_DEPTH+1)-1:0] credit_cnt_t;

  // one bit per port, one bit per VC
  typedef logic [`VC_ROUTER_NUM_PORTS-1:0] port_mask_t;
  typedef logic [`VC_ROUTER_NUM_VC-1:0]    vc_mask_t;

  typedef logic [`VC_ROUTER_PAYLOAD_W-1:0] payload_t;

  // dst names the output port directly
  typedef struct packed {
    port_idx_t dst;
    vc_idx_t   vc;
    logic      last;
    payload_t  payload;
  } flit_t;

  // per output wormhole lock
  typedef enum logic {
    LOCK_IDLE,
    LOCK_HELD
  } lock_state_e;

endpackage

`default_nettype wire

//--- src/alloc_if.sv
// ==================================================
// allocation result bus
// switch grants per output, buffer pops per input
// ==================================================
`timescale 1ns/1ns
`default_nettype none
`include "vc_router_cfg.svh"

interface alloc_if;
  import vc_router_pkg::*;

  // per output: a flit moves this cycle
  port_mask_t                           grant_v;
  port_idx_t [`VC_ROUTER_NUM_PORTS-1:0] grant_in;
  vc_idx_t   [`VC_ROUTER_NUM_PORTS-1:0] grant_vc;
  // downstream VC the flit leaves on
  vc_idx_t   [`VC_ROUTER_NUM_PORTS-1:0] out_vc;

  // per input: pop the head of read_vc
  port_mask_t                           read_v;
  vc_idx_t   [`VC_ROUTER_NUM_PORTS-1:0] read_vc;

  modport alloc  (output grant_v, grant_in, grant_vc, out_vc, read_v, read_vc);
  modport inport (input read_v, read_vc);
  modport xbar   (input grant_v, grant_in, grant_vc, out_vc);
  modport lock   (input grant_v, grant_in, grant_vc, out_vc);

endinterface

`default_nettype wire

//--- src/vc_input_port.sv
// ==================================================
// router input port
// one circular buffer per VC, head flits to the
// allocator, one credit back per popped flit
// ==================================================
`timescale 1ns/1ns
`default_nettype none
`include "vc_router_cfg.svh"

module vc_input_port #(
  parameter int PORT_ID = 0
) (
  input  logic                                         clk_i,
  input  logic                                         arst_n_i,
  input  logic                                         data_v_i,
  input  vc_router_pkg::flit_t                         data_i,
  output vc_router_pkg::vc_mask_t                      head_v_o,
  output vc_router_pkg::flit_t [`VC_ROUTER_NUM_VC-1:0] head_flit_o,
  alloc_if.inport                                      alloc,
  output logic                                         credit_v_o,
  output vc_router_pkg::vc_idx_t                       credit_id_o
);
  import vc_router_pkg::*;

  localparam int NUM_VC = `VC_ROUTER_NUM_VC;
  localparam int DEPTH  = `VC_ROUTER_VC_DEPTH;
  localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef logic [PTR_W-1:0] ptr_t;

  flit_t       mem_q    [NUM_VC][DEPTH];
  ptr_t        wr_ptr_q [NUM_VC];
  ptr_t        rd_ptr_q [NUM_VC];
  credit_cnt_t fill_q   [NUM_VC];
  vc_mask_t    push;
  vc_mask_t    pop;

  function automatic ptr_t ptr_inc(input ptr_t p);
    return (p == ptr_t'(DEPTH-1)) ? '0 : p + ptr_t'(1);
  endfunction

  always_comb begin
    for (int v = 0; v < NUM_VC; v++) begin
      // arriving flit goes to the VC it names
      push[v]        = data_v_i && (data_i.vc == vc_idx_t'(v));
      pop[v]         = alloc.read_v[PORT_ID] && (alloc.read_vc[PORT_ID] == vc_idx_t'(v));
      head_v_o[v]    = (fill_q[v] != '0);
      head_flit_o[v] = mem_q[v][rd_ptr_q[v]];
    end
  end

  always_ff @(posedge clk_i) begin
    for (int v = 0; v < NUM_VC; v++) begin
      if (push[v]) begin
        mem_q[v][wr_ptr_q[v]] <= data_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int v = 0; v < NUM_VC; v++) begin
        wr_ptr_q[v] <= '0;
        rd_ptr_q[v] <= '0;
        fill_q[v]   <= '0;
      end
    end else begin
      for (int v = 0; v < NUM_VC; v++) begin
        if (push[v]) begin
          wr_ptr_q[v] <= ptr_inc(wr_ptr_q[v]);
        end
        if (pop[v]) begin
          rd_ptr_q[v] <= ptr_inc(rd_ptr_q[v]);
        end
        if (push[v] && !pop[v]) begin
          fill_q[v] <= fill_q[v] + credit_cnt_t'(1);
        end else if (pop[v] && !push[v]) begin
          fill_q[v] <= fill_q[v] - credit_cnt_t'(1);
        end
      end
    end
  end

  // freed slot goes back upstream one cycle after the pop
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credit_v_o  <= 1'b0;
      credit_id_o <= '0;
    end else begin
      credit_v_o  <= alloc.read_v[PORT_ID];
      credit_id_o <= alloc.read_vc[PORT_ID];
    end
  end

endmodule

`default_nettype wire

//--- src/vc_credit_counter.sv
// ==================================================
// output credit counters
// free slots per downstream VC of one output
// ==================================================
`timescale 1ns/1ns
`default_nettype none
`include "vc_router_cfg.svh"

module vc_credit_counter (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    credit_v_i,
  input  vc_router_pkg::vc_idx_t  credit_id_i,
  input  logic                    consume_v_i,
  input  vc_router_pkg::vc_idx_t  consume_vc_i,
  output vc_router_pkg::vc_mask_t vc_has_credit_o
);
  import vc_router_pkg::*;

  localparam int NUM_VC = `VC_ROUTER_NUM_VC;

  credit_cnt_t cnt_q [NUM_VC];
  vc_mask_t    ret;
  vc_mask_t    use_c;

  always_comb begin
    for (int v = 0; v < NUM_VC; v++) begin
      ret[v]             = credit_v_i && (credit_id_i == vc_idx_t'(v));
      use_c[v]           = consume_v_i && (consume_vc_i == vc_idx_t'(v));
      vc_has_credit_o[v] = (cnt_q[v] != '0);
    end
  end

  // a return and a consume on the same VC cancel
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int v = 0; v < NUM_VC; v++) begin
        cnt_q[v] <= credit_cnt_t'(`VC_ROUTER_VC_DEPTH);
      end
    end else begin
      for (int v = 0; v < NUM_VC; v++) begin
        if (ret[v] && !use_c[v]) begin
          cnt_q[v] <= cnt_q[v] + credit_cnt_t'(1);
        end else if (use_c[v] && !ret[v]) begin
          cnt_q[v] <= cnt_q[v] - credit_cnt_t'(1);
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- src/wormhole_lock_fsm.sv
// ==================================================
// wormhole lock and output VC assignment
// holds one output for a multi-flit packet and
// picks the downstream VC for each grant
// ==================================================
`timescale 1ns/1ns
`default_nettype none
`include "vc_router_cfg.svh"

module wormhole_lock_fsm #(
  parameter int PORT_ID = 0
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  alloc_if.lock                     alloc,
  input  logic                      last_i,
  input  vc_router_pkg::vc_mask_t   vc_has_credit_i,
  output logic                      out_ready_o,
  output logic                      lock_held_o,
  output vc_router_pkg::port_idx_t  lock_in_o,
  output vc_router_pkg::vc_idx_t    lock_vc_o,
  output vc_router_pkg::vc_idx_t    next_out_vc_o
);
  import vc_router_pkg::*;

  lock_state_e state_q;
  lock_state_e state_d;
  port_idx_t   lock_in_q;
  vc_idx_t     lock_vc_q;
  vc_idx_t     lock_out_vc_q;
  vc_idx_t     free_vc;
  logic        granted;

  assign granted = alloc.grant_v[PORT_ID];

  // lowest numbered VC that still has credit
  always_comb begin
    free_vc = '0;
    for (int v = `VC_ROUTER_NUM_VC-1; v >= 0; v--) begin
      if (vc_has_credit_i[v]) begin
        free_vc = vc_idx_t'(v);
      end
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      LOCK_IDLE: if (granted && !last_i) state_d = LOCK_HELD;
      LOCK_HELD: if (granted && last_i) state_d = LOCK_IDLE;
      default:   state_d = LOCK_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q       <= LOCK_IDLE;
      lock_in_q     <= '0;
      lock_vc_q     <= '0;
      lock_out_vc_q <= '0;
    end else begin
      state_q <= state_d;
      // head of a multi-flit packet pins input, input VC and out VC
      if (state_q == LOCK_IDLE && state_d == LOCK_HELD) begin
        lock_in_q     <= alloc.grant_in[PORT_ID];
        lock_vc_q     <= alloc.grant_vc[PORT_ID];
        lock_out_vc_q <= alloc.out_vc[PORT_ID];
      end
    end
  end

  assign lock_held_o   = (state_q == LOCK_HELD);
  assign lock_in_o     = lock_in_q;
  assign lock_vc_o     = lock_vc_q;
  assign next_out_vc_o = lock_held_o ? lock_out_vc_q : free_vc;
  assign out_ready_o   = lock_held_o ? vc_has_credit_i[lock_out_vc_q] : |vc_has_credit_i;

endmodule

`default_nettype wire

//--- src/vc_switch_alloc.sv
// ==================================================
// separable switch allocator
// round-robin VC pick per input, then round-robin
// input pick per output, both bent by the locks
// ==================================================
`timescale 1ns/1ns
`default_nettype none
`include "vc_router_cfg.svh"

module vc_switch_alloc (
  input  logic                                                 clk_i,
  input  logic                                                 arst_n_i,
  input  vc_router_pkg::vc_mask_t  [`VC_ROUTER_NUM_PORTS-1:0] head_v_i,
  input  vc_router_pkg::flit_t     [`VC_ROUTER_NUM_PORTS-1:0]
                                   [`VC_ROUTER_NUM_VC-1:0]     head_flit_i,
  input  vc_router_pkg::port_mask_t                            out_ready_i,
  input  vc_router_pkg::port_mask_t                            lock_held_i,
  input  vc_router_pkg::port_idx_t [`VC_ROUTER_NUM_PORTS-1:0] lock_in_i,
  input  vc_router_pkg::vc_idx_t   [`VC_ROUTER_NUM_PORTS-1:0] lock_vc_i,
  input  vc_router_pkg::vc_idx_t   [`VC_ROUTER_NUM_PORTS-1:0] next_out_vc_i,
  alloc_if.alloc                                               alloc
);
  import vc_router_pkg::*;

  localparam int NP = `VC_ROUTER_NUM_PORTS;
  localparam int NV = `VC_ROUTER_NUM_VC;
  localparam int RW = (NP > NV) ? NP : NV;

  vc_idx_t            in_ptr_q  [NP];
  port_idx_t          out_ptr_q [NP];

  // local winner of each input
  port_mask_t         loc_v;
  vc_idx_t   [NP-1:0] loc_vc;
  port_idx_t [NP-1:0] loc_dst;

  port_mask_t         grant_v;
  port_idx_t [NP-1:0] grant_in;
  port_mask_t         read_v;

  // first request at or after ptr, -1 when none
  function automatic int rr_pick(input logic [RW-1:0] req, input int ptr, input int n);
    int idx;
    int pick;
    pick = -1;
    for (int k = RW-1; k >= 0; k--) begin
      idx = ptr + k;
      if (idx >= n) begin
        idx = idx - n;
      end
      if (k < n && req[idx]) begin
        pick = idx;
      end
    end
    return pick;
  endfunction

  // ==================================================
  // local stage, one VC per input
  // ==================================================
  always_comb begin : local_sa
    logic [RW-1:0] req;
    logic          held;
    vc_idx_t       held_vc;
    port_idx_t     d;
    int            pick;
    for (int i = 0; i < NP; i++) begin
      held    = 1'b0;
      held_vc = '0;
      for (int o = 0; o < NP; o++) begin
        if (lock_held_i[o] && lock_in_i[o] == port_idx_t'(i)) begin
          held    = 1'b1;
          held_vc = lock_vc_i[o];
        end
      end
      req = '0;
      for (int v = 0; v < NV; v++) begin
        d      = head_flit_i[i][v].dst;
        // skip outputs without credit or locked to someone else
        req[v] = head_v_i[i][v] && (int'(d) < NP) && out_ready_i[d] &&
                 (!lock_held_i[d] || lock_in_i[d] == port_idx_t'(i)) &&
                 (!held || held_vc == vc_idx_t'(v));
      end
      pick       = rr_pick(req, int'(in_ptr_q[i]), NV);
      loc_v[i]   = (pick >= 0);
      loc_vc[i]  = (pick >= 0) ? vc_idx_t'(pick) : '0;
      loc_dst[i] = head_flit_i[i][loc_vc[i]].dst;
    end
  end

  // ==================================================
  // global stage, one input per output
  // ==================================================
  always_comb begin : global_sa
    logic [RW-1:0] req;
    int            pick;
    read_v = '0;
    for (int o = 0; o < NP; o++) begin
      req = '0;
      for (int i = 0; i < NP; i++) begin
        req[i] = loc_v[i] && (loc_dst[i] == port_idx_t'(o)) &&
                 (!lock_held_i[o] || lock_in_i[o] == port_idx_t'(i));
      end
      pick        = rr_pick(req, int'(out_ptr_q[o]), NP);
      grant_v[o]  = (pick >= 0);
      grant_in[o] = (pick >= 0) ? port_idx_t'(pick) : '0;
      if (grant_v[o]) begin
        read_v[grant_in[o]] = 1'b1;
      end
    end
  end

  assign alloc.grant_v  = grant_v;
  assign alloc.grant_in = grant_in;
  assign alloc.out_vc   = next_out_vc_i;
  assign alloc.read_v   = read_v;
  assign alloc.read_vc  = loc_vc;

  always_comb begin
    for (int o = 0; o < NP; o++) begin
      alloc.grant_vc[o] = loc_vc[grant_in[o]];
    end
  end

  // pointers move one past the winner
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int p = 0; p < NP; p++) begin
        in_ptr_q[p]  <= '0;
        out_ptr_q[p] <= '0;
      end
    end else begin
      for (int p = 0; p < NP; p++) begin
        if (read_v[p]) begin
          in_ptr_q[p] <= (int'(loc_vc[p]) == NV-1) ? '0 : loc_vc[p] + vc_idx_t'(1);
        end
        if (grant_v[p]) begin
          out_ptr_q[p] <= (int'(grant_in[p]) == NP-1) ? '0 : grant_in[p] + port_idx_t'(1);
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- src/vc_crossbar.sv
// ==================================================
// switch traversal
// per output mux, VC rewrite, output register
// ==================================================
`timescale 1ns/1ns
`default_nettype none
`include "vc_router_cfg.svh"

module vc_crossbar (
  input  logic                                             clk_i,
  input  logic                                             arst_n_i,
  input  vc_router_pkg::flit_t [`VC_ROUTER_NUM_PORTS-1:0]
                               [`VC_ROUTER_NUM_VC-1:0]     head_flit_i,
  alloc_if.xbar                                            alloc,
  output vc_router_pkg::port_mask_t                        sel_last_o,
  output vc_router_pkg::port_mask_t                        data_v_o,
  output vc_router_pkg::flit_t [`VC_ROUTER_NUM_PORTS-1:0] data_o
);
  import vc_router_pkg::*;

  localparam int NP = `VC_ROUTER_NUM_PORTS;

  flit_t [NP-1:0] sel_flit;

  always_comb begin
    for (int o = 0; o < NP; o++) begin
      sel_flit[o]    = head_flit_i[alloc.grant_in[o]][alloc.grant_vc[o]];
      // leaves on the downstream VC, not the one it came in on
      sel_flit[o].vc = alloc.out_vc[o];
      sel_last_o[o]  = sel_flit[o].last;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      data_v_o <= '0;
    end else begin
      data_v_o <= alloc.grant_v;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int o = 0; o < NP; o++) begin
      if (alloc.grant_v[o]) begin
        data_o[o] <= sel_flit[o];
      end
    end
  end

endmodule

`default_nettype wire

//--- src/vc_router.sv
// ==================================================
// vc_router top level
// three port virtual channel router with credit
// flow control and wormhole locking
// ==================================================
`timescale 1ns/1ns
`default_nettype none
`include "vc_router_cfg.svh"

module vc_router (
  input  logic                                               clk_i,
  input  logic                                               arst_n_i,
  input  vc_router_pkg::port_mask_t                          data_v_i,
  input  vc_router_pkg::flit_t    [`VC_ROUTER_NUM_PORTS-1:0] data_i,
  output vc_router_pkg::port_mask_t                          credit_v_o,
  output vc_router_pkg::vc_idx_t  [`VC_ROUTER_NUM_PORTS-1:0] credit_id_o,
  output vc_router_pkg::port_mask_t                          data_v_o,
  output vc_router_pkg::flit_t    [`VC_ROUTER_NUM_PORTS-1:0] data_o,
  input  vc_router_pkg::port_mask_t                          credit_v_i,
  input  vc_router_pkg::vc_idx_t  [`VC_ROUTER_NUM_PORTS-1:0] credit_id_i
);
  import vc_router_pkg::*;

  localparam int NP = `VC_ROUTER_NUM_PORTS;
  localparam int NV = `VC_ROUTER_NUM_VC;

  // head bus, per input per VC
  vc_mask_t  [NP-1:0]         head_v;
  flit_t     [NP-1:0][NV-1:0] head_flit;

  // per output state
  vc_mask_t  [NP-1:0]         vc_has_credit;
  port_mask_t                 out_ready;
  port_mask_t                 lock_held;
  port_idx_t [NP-1:0]         lock_in;
  vc_idx_t   [NP-1:0]         lock_vc;
  vc_idx_t   [NP-1:0]         next_out_vc;
  port_mask_t                 sel_last;

  alloc_if alloc_bus ();

  for (genvar p = 0; p < NP; p++) begin : gen_port
    vc_input_port #(
      .PORT_ID (p)
    ) u_input_port (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .data_v_i    (data_v_i[p]),
      .data_i      (data_i[p]),
      .head_v_o    (head_v[p]),
      .head_flit_o (head_flit[p]),
      .alloc       (alloc_bus.inport),
      .credit_v_o  (credit_v_o[p]),
      .credit_id_o (credit_id_o[p])
    );

    vc_credit_counter u_credit_counter (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .credit_v_i      (credit_v_i[p]),
      .credit_id_i     (credit_id_i[p]),
      .consume_v_i     (alloc_bus.grant_v[p]),
      .consume_vc_i    (alloc_bus.out_vc[p]),
      .vc_has_credit_o (vc_has_credit[p])
    );

    wormhole_lock_fsm #(
      .PORT_ID (p)
    ) u_lock_fsm (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .alloc           (alloc_bus.lock),
      .last_i          (sel_last[p]),
      .vc_has_credit_i (vc_has_credit[p]),
      .out_ready_o     (out_ready[p]),
      .lock_held_o     (lock_held[p]),
      .lock_in_o       (lock_in[p]),
      .lock_vc_o       (lock_vc[p]),
      .next_out_vc_o   (next_out_vc[p])
    );
  end

  vc_switch_alloc u_switch_alloc (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .head_v_i      (head_v),
    .head_flit_i   (head_flit),
    .out_ready_i   (out_ready),
    .lock_held_i   (lock_held),
    .lock_in_i     (lock_in),
    .lock_vc_i     (lock_vc),
    .next_out_vc_i (next_out_vc),
    .alloc         (alloc_bus.alloc)
  );

  vc_crossbar u_crossbar (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .head_flit_i (head_flit),
    .alloc       (alloc_bus.xbar),
    .sel_last_o  (sel_last),
    .data_v_o    (data_v_o),
    .data_o      (data_o)
  );

endmodule

`default_nettype wire

//--- tb/tb_vc_router.sv
// ==================================================
// vc_router testbench
// random packets from credit-following senders,
// receiver models with delayed credit return
// ==================================================
`timescale 1ns/1ns
`default_nettype none
`include "vc_router_cfg.svh"

module tb_vc_router;
  import vc_router_pkg::*;

  localparam int NP      = `VC_ROUTER_NUM_PORTS;
  localparam int NV      = `VC_ROUTER_NUM_VC;
  localparam int DEPTH   = `VC_ROUTER_VC_DEPTH;
  localparam int PW      = `VC_ROUTER_PAYLOAD_W;
  localparam int SEQ_W   = PW - $bits(port_idx_t) - $bits(vc_idx_t);
  localparam int NS      = NP * NV;
  localparam int QD      = 16;
  localparam int TIMEOUT = 3000;

  // payload carries its source stream so a receiver can find it
  typedef struct packed {
    port_idx_t        src;
    vc_idx_t          vc;
    logic [SEQ_W-1:0] seq;
  } tag_t;

  logic                clk_i;
  logic                arst_n_i;
  port_mask_t          data_v_i;
  flit_t   [NP-1:0]    data_i;
  port_mask_t          credit_v_o;
  vc_idx_t [NP-1:0]    credit_id_o;
  port_mask_t          data_v_o;
  flit_t   [NP-1:0]    data_o;
  port_mask_t          credit_v_i;
  vc_idx_t [NP-1:0]    credit_id_i;

  vc_router dut_i (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .data_v_i    (data_v_i),
    .data_i      (data_i),
    .credit_v_o  (credit_v_o),
    .credit_id_o (credit_id_o),
    .data_v_o    (data_v_o),
    .data_o      (data_o),
    .credit_v_i  (credit_v_i),
    .credit_id_i (credit_id_i)
  );

  logic [31:0] lfsr_q;
  int          cycle;
  int          errors;
  int          tests_run;
  int          tests_failed;
  logic        hold_credits;
  logic        timed_out;

  // sender models per input
  int          pkts_left  [NP];
  int          flits_left [NP];
  port_idx_t   pkt_dst    [NP];
  vc_idx_t     pkt_vc     [NP];
  int          seq        [NP];
  int          snd_cred   [NP][NV];
  int          in_flight  [NP][NV];

  // expected flits per input stream
  flit_t       exp_mem [NS][QD];
  int          exp_wr  [NS];
  int          exp_rd  [NS];

  // receiver models per output
  int          rx_cred    [NP][NV];
  int          rx_hold    [NP][NV];
  int          ret_due    [NP][QD];
  vc_idx_t     ret_vc     [NP][QD];
  int          ret_wr     [NP];
  int          ret_rd     [NP];
  logic        pkt_open   [NP];
  int          pkt_key    [NP];
  vc_idx_t     pkt_out_vc [NP];

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // fibonacci LFSR with taps 32 22 2 1 and one step per bit
  function automatic int rand_bits(input int n);
    int   r;
    logic fb;
    r = 0;
    for (int k = 0; k < n; k++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = (r << 1) | int'(fb);
    end
    return r;
  endfunction

  function automatic int rand_under(input int n);
    int r;
    int w;
    w = $clog2(n);
    r = rand_bits(w);
    while (r >= n) begin
      r = rand_bits(w);
    end
    return r;
  endfunction

  task automatic check_credit_return();
    vc_idx_t v;
    for (int i = 0; i < NP; i++) begin
      if (credit_v_o[i]) begin
        v = credit_id_o[i];
        if (in_flight[i][v] == 0) begin
          $display("ERROR: input %0d returned a credit for VC %0d with no flit held", i, v);
          errors++;
        end else begin
          in_flight[i][v]--;
          snd_cred[i][v]++;
        end
      end
    end
  endtask

  task automatic check_outputs();
    flit_t f;
    flit_t e;
    tag_t  t;
    int    k;
    for (int o = 0; o < NP; o++) begin
      if (data_v_o[o]) begin
        f = data_o[o];
        t = tag_t'(f.payload);
        k = int'(t.src) * NV + int'(t.vc);
        if (int'(t.src) >= NP || exp_rd[k] == exp_wr[k]) begin
          $display("ERROR: output %0d delivered a flit that was never sent", o);
          errors++;
        end else begin
          e = exp_mem[k][exp_rd[k] % QD];
          exp_rd[k]++;
          if (int'(e.dst) != o) begin
            $display("ERROR: flit for output %0d came out of output %0d", e.dst, o);
            errors++;
          end
          if (f.dst != e.dst) begin
            $display("[FAIL] data_o[%0d].dst got %h expected %h", o, f.dst, e.dst);
            errors++;
          end
          if (f.payload != e.payload) begin
            $display("[FAIL] data_o[%0d].payload got %h expected %h", o, f.payload, e.payload);
            errors++;
          end
          if (f.last != e.last) begin
            $display("[FAIL] data_o[%0d].last got %h expected %h", o, f.last, e.last);
            errors++;
          end
        end
        // receiver must have room on the out VC
        if (rx_cred[o][f.vc] == 0) begin
          $display("ERROR: output %0d sent on VC %0d with no credit left", o, f.vc);
          errors++;
        end else begin
          rx_cred[o][f.vc]--;
          ret_due[o][ret_wr[o] % QD] = cycle + rand_bits(2);
          ret_vc[o][ret_wr[o] % QD]  = f.vc;
          ret_wr[o]++;
        end
        if (hold_credits) begin
          rx_hold[o][f.vc]++;
        end
        // open wormhole packet keeps one stream and one out VC until last
        if (pkt_open[o]) begin
          if (k != pkt_key[o]) begin
            $display("ERROR: output %0d mixed another packet into an open packet", o);
            errors++;
          end
          if (f.vc != pkt_out_vc[o]) begin
            $display("[FAIL] data_o[%0d].vc got %h expected %h", o, f.vc, pkt_out_vc[o]);
            errors++;
          end
        end else begin
          pkt_key[o]    = k;
          pkt_out_vc[o] = f.vc;
        end
        pkt_open[o] = !f.last;
      end
    end
  endtask

  task automatic drive_credits();
    int r;
    credit_v_i  = '0;
    credit_id_i = '0;
    for (int o = 0; o < NP; o++) begin
      r = ret_rd[o] % QD;
      if (!hold_credits && ret_rd[o] != ret_wr[o] && ret_due[o][r] <= cycle) begin
        credit_v_i[o]  = 1'b1;
        credit_id_i[o] = ret_vc[o][r];
        rx_cred[o][ret_vc[o][r]]++;
        ret_rd[o]++;
      end
    end
  endtask

  task automatic drive_senders();
    flit_t f;
    tag_t  t;
    int    k;
    data_v_i = '0;
    for (int i = 0; i < NP; i++) begin
      if (flits_left[i] == 0 && pkts_left[i] > 0) begin
        pkts_left[i]--;
        flits_left[i] = 1 + rand_under(3);
        pkt_dst[i]    = port_idx_t'(rand_under(NP));
        pkt_vc[i]     = vc_idx_t'(rand_under(NV));
      end
      if (flits_left[i] > 0 && snd_cred[i][pkt_vc[i]] > 0 && rand_bits(2) != 0) begin
        t.src     = port_idx_t'(i);
        t.vc      = pkt_vc[i];
        t.seq     = SEQ_W'(seq[i]);
        f.dst     = pkt_dst[i];
        f.vc      = pkt_vc[i];
        f.last    = (flits_left[i] == 1);
        f.payload = t;
        data_i[i]   = f;
        data_v_i[i] = 1'b1;
        seq[i]++;
        flits_left[i]--;
        snd_cred[i][pkt_vc[i]]--;
        in_flight[i][pkt_vc[i]]++;
        k = i * NV + int'(pkt_vc[i]);
        if (exp_wr[k] - exp_rd[k] >= QD) begin
          $display("ERROR: too many flits of input %0d VC %0d in flight", i, pkt_vc[i]);
          errors++;
        end
        exp_mem[k][exp_wr[k] % QD] = f;
        exp_wr[k]++;
      end
    end
  endtask

  // sample registered outputs and then drive inputs
  task automatic step();
    @(negedge clk_i);
    cycle++;
    check_credit_return();
    check_outputs();
    drive_credits();
    drive_senders();
  endtask

  function automatic logic drained();
    logic d;
    d = 1'b1;
    for (int p = 0; p < NP; p++) begin
      if (pkts_left[p] != 0 || flits_left[p] != 0 || ret_rd[p] != ret_wr[p]) begin
        d = 1'b0;
      end
      for (int v = 0; v < NV; v++) begin
        if (snd_cred[p][v] != DEPTH || rx_cred[p][v] != DEPTH) begin
          d = 1'b0;
        end
      end
    end
    for (int k = 0; k < NS; k++) begin
      if (exp_rd[k] != exp_wr[k]) begin
        d = 1'b0;
      end
    end
    return d;
  endfunction

  task automatic wait_drained(input string what);
    int n;
    n = 0;
    while (!drained() && n < TIMEOUT) begin
      step();
      n++;
    end
    if (!drained()) begin
      $display("ERROR: %s did not drain within %0d cycles", what, TIMEOUT);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - errs_before);
    end
  endtask

  // ==================================================
  // test sequence
  // ==================================================
  initial begin
    int e0;
    lfsr_q       = 32'h8d47_bbf7;
    cycle        = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    hold_credits = 1'b0;
    timed_out    = 1'b0;
    for (int p = 0; p < NP; p++) begin
      pkts_left[p]  = 0;
      flits_left[p] = 0;
      pkt_dst[p]    = '0;
      pkt_vc[p]     = '0;
      seq[p]        = 0;
      ret_wr[p]     = 0;
      ret_rd[p]     = 0;
      pkt_open[p]   = 1'b0;
      pkt_key[p]    = 0;
      pkt_out_vc[p] = '0;
      for (int v = 0; v < NV; v++) begin
        snd_cred[p][v]  = DEPTH;
        in_flight[p][v] = 0;
        rx_cred[p][v]   = DEPTH;
        rx_hold[p][v]   = 0;
      end
    end
    for (int k = 0; k < NS; k++) begin
      exp_wr[k] = 0;
      exp_rd[k] = 0;
    end
    arst_n_i    = 1'b0;
    data_v_i    = '0;
    data_i      = '0;
    credit_v_i  = '0;
    credit_id_i = '0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    // quiet outputs with no traffic
    e0 = errors;
    for (int c = 0; c < 5; c++) begin
      step();
      if (data_v_o !== '0) begin
        $display("[FAIL] data_v_o got %h expected %h", data_v_o, port_mask_t'(0));
        errors++;
      end
      if (credit_v_o !== '0) begin
        $display("[FAIL] credit_v_o got %h expected %h", credit_v_o, port_mask_t'(0));
        errors++;
      end
    end
    report_test("idle after reset", e0);

    // mixed packets with credits returned after 0 to 3 cycles
    e0 = errors;
    for (int p = 0; p < NP; p++) begin
      pkts_left[p] = 12;
    end
    wait_drained("random traffic");
    report_test("random traffic", e0);

    if (!timed_out) begin
      // receivers withhold credits and later release them
      e0 = errors;
      hold_credits = 1'b1;
      for (int p = 0; p < NP; p++) begin
        pkts_left[p] = 6;
      end
      repeat (80) step();
      for (int o = 0; o < NP; o++) begin
        for (int v = 0; v < NV; v++) begin
          if (rx_hold[o][v] > DEPTH) begin
            $display("[FAIL] data_o[%0d] flits on VC %0d got %h expected at most %h",
                     o, v, rx_hold[o][v], DEPTH);
            errors++;
          end
        end
      end
      hold_credits = 1'b0;
      wait_drained("back-pressure traffic");
      report_test("back-pressure", e0);
    end

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vc_router.f
+incdir+include
src/vc_router_pkg.sv
src/alloc_if.sv
src/vc_input_port.sv
src/vc_credit_counter.sv
src/wormhole_lock_fsm.sv
src/vc_switch_alloc.sv
src/vc_crossbar.sv
src/vc_router.sv
tb/tb_vc_router.sv
